// File: vlog.f
source/cacheGeomPkg.sv
source/cacheBusPkg.sv
source/sram.sv
source/cacheController.sv
source/l1DataCache.sv
verification/cacheProtocol_assert.sv
verification/l1DataCacheTb.sv

// File: Makefile
# Verilator build and run of the L1 data cache testbench

SOURCES := $(shell cat vlog.f)
SIM     := obj_dir/Vl1DataCacheTb

all: $(SIM)

# rebuilt only when the file list or a source changes
$(SIM): vlog.f $(SOURCES)
	verilator --binary --timing --assert --top-module l1DataCacheTb -f vlog.f -o Vl1DataCacheTb

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: verification/l1DataCacheTb.sv
/*
 * L1 data cache testbench
 * Directed and LFSR driven reads and writes checked against a shadow
 * word model, with a memory model that answers after a random delay.
 */
`timescale 1ns/1ps

module l1DataCacheTb import cacheGeomPkg::*, cacheBusPkg::*; ();

    localparam int clkPeriod      = 40;
    localparam int resetCycles    = 16;
    localparam int numDirectedOps = 9;
    localparam int numRandomOps   = 2000;
    localparam int maxMemDelay    = 6;
    localparam int hitEdges       = 3;  // valid sampled, lookup, done
    localparam int timeoutCycles  = resetCycles + 8
                                  + (numDirectedOps + numRandomOps) * (2 + maxMemDelay + 8);

    logic    CLK;
    logic    reset;
    cpuReqT  cpuReq;
    cpuRespT cpuResp;
    memReqT  memReq;
    memRespT memResp;

    logic [31:0]         lfsrState = 32'h6415_ccda;
    logic [31:0]         shadowWords [int unsigned];  // reference image, word address key
    logic [31:0]         memWords [int unsigned];     // memory model contents
    logic [tagWidth-1:0] tagChoices [4] = '{24'h00_0000, 24'h00_0001, 24'h5A_A5C3, 24'hFF_FFFF};
    logic [tagWidth-1:0] refTags [numSets];
    logic [numSets-1:0]  refValid;
    memReqT              lastMemReq;                  // first sight of each memory request
    int                  memReadCount;
    int                  memWriteCount;
    int                  memDelay;                    // ready delay for the current op
    int                  cycleCount;

    l1DataCache l1DataCache_i (
        .CLK     (CLK),
        .reset   (reset),
        .cpuReq  (cpuReq),
        .cpuResp (cpuResp),
        .memReq  (memReq),
        .memResp (memResp)
    );

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};  // fibonacci, taps 32 22 2 1
            bits      = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // power up contents, hash of the whole word address
    function automatic logic [31:0] initWord(input logic [31:0] wordAddr);
        return (wordAddr * 32'h9E37_79B1) ^ {wordAddr[15:0], wordAddr[31:16]};
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [bytesPerWord-1:0] byteEn);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < bytesPerWord; b++) begin
            if (byteEn[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];  // enabled byte replaced
            end
        end
        return word;
    endfunction

    // reference model: stores merge into the shadow, every access returns the word
    function automatic logic [31:0] expectedWord(input cpuReqT req);
        int unsigned key;
        logic [31:0] word;
        key  = {2'b00, req.addr[31:2]};
        word = shadowWords.exists(key) ? shadowWords[key] : initWord(key);
        if (req.write) begin
            word             = mergeBytes(word, req.wdata, req.byteEn);
            shadowWords[key] = word;
        end
        return word;
    endfunction

    // four tags on four sets, so 64 word addresses
    function automatic logic [31:0] makeAddr(input logic [1:0] tagSel, input logic [1:0] setSel,
                                             input logic [1:0] wordSel);
        cacheAddrT a;
        a.tag     = tagChoices[tagSel];
        a.index   = {setSel, ~setSel};  // sets 3, 6, 9, 12
        a.wordSel = wordSel;
        a.byteSel = '0;
        return a;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one request, called on a falling edge and returns on a falling edge
    task automatic runOp(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [bytesPerWord-1:0] byteEn, input int delay);
        memDelay      = delay;
        cpuReq.valid  = 1'b1;
        cpuReq.write  = write;
        cpuReq.addr   = addr;
        cpuReq.wdata  = wdata;
        cpuReq.byteEn = byteEn;
        @(posedge CLK);
        while (!cpuResp.done) begin
            @(posedge CLK);
        end
        @(negedge CLK);
        cpuReq.valid = 1'b0;  // a following call raises it again at once
    endtask

    // ==============================
    // clock and timeout
    // ==============================
    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("timeout, the test did not finish within %0d cycles", timeoutCycles);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation timed out");
    end

    // ==============================
    // memory model
    // ==============================
    initial begin : memoryModel
        int unsigned lineKey;
        int unsigned wordKey;
        lineT        line;
        memResp       = '0;
        memReadCount  = 0;
        memWriteCount = 0;
        forever begin
            @(posedge CLK);
            if (!reset && memReq.valid) begin
                lastMemReq = memReq;
                if (memReq.write) memWriteCount++;
                else              memReadCount++;
                repeat (memDelay) @(negedge CLK);   // 1 to 6 cycles
                lineKey = {2'b00, memReq.addr[31:4], 2'b00};
                wordKey = {2'b00, memReq.addr[31:2]};
                if (memReq.write) begin
                    memWords[wordKey] = mergeBytes(memWords.exists(wordKey) ?
                        memWords[wordKey] : initWord(wordKey), memReq.wdata, memReq.byteEn);
                end else begin
                    for (int w = 0; w < lineWords; w++) begin
                        wordKey = lineKey + 32'(w);
                        line[w] = memWords.exists(wordKey) ? memWords[wordKey] : initWord(wordKey);
                    end
                    memResp.rline = line;
                end
                memResp.ready = 1'b1;
                @(negedge CLK);
                memResp.ready = 1'b0;               // one cycle pulse
            end
        end
    end

    // ==============================
    // compare
    // ==============================
    initial begin : compareResults
        cpuReqT      req;
        cacheAddrT   fields;
        logic [31:0] expected;
        logic        expectHit;
        int          edgesSeen;
        int          readBase;
        int          writeBase;
        refValid  = '0;  // cache starts empty
        edgesSeen = 0;
        readBase  = 0;
        writeBase = 0;
        forever begin
            @(posedge CLK);
            if (!reset && !cpuReq.valid) begin
                checkValue("cpuResp.done", 32'(cpuResp.done), 0);    // quiet with no request
                checkValue("memReq.valid", 32'(memReq.valid), 0);
            end else if (!reset) begin
                edgesSeen++;
                if (cpuResp.done) begin
                    req       = cpuReq;
                    fields    = cacheAddrT'(req.addr);
                    expectHit = refValid[fields.index] && (refTags[fields.index] == fields.tag);
                    expected  = expectedWord(req);
                    if (req.write) begin
                        checkValue("memory writes", memWriteCount - writeBase, 1);
                        checkValue("memory reads", memReadCount - readBase, 0);
                        checkValue("memReq.addr", lastMemReq.addr, req.addr);
                        checkValue("memReq.wdata", lastMemReq.wdata, req.wdata);
                        checkValue("memReq.byteEn", 32'(lastMemReq.byteEn), 32'(req.byteEn));
                    end else begin
                        checkValue("cpuResp.rdata", cpuResp.rdata, expected);
                        checkValue("memory writes", memWriteCount - writeBase, 0);
                        if (expectHit) begin
                            checkValue("memory reads", memReadCount - readBase, 0);
                            checkValue("hit latency", edgesSeen, hitEdges);
                        end else begin
                            checkValue("memory reads", memReadCount - readBase, 1);
                            checkValue("memReq.addr", lastMemReq.addr, {req.addr[31:4], 4'h0});
                            refValid[fields.index] = 1'b1;  // line now held, old tag evicted
                            refTags[fields.index]  = fields.tag;
                        end
                    end
                    edgesSeen = 0;
                    readBase  = memReadCount;
                    writeBase = memWriteCount;
                end
            end
        end
    end

    // ==============================
    // stimulus
    // ==============================
    initial begin : stimulus
        logic                    isWrite;
        logic [1:0]              tagSel;
        logic [1:0]              setSel;
        logic [1:0]              wordSel;
        logic [31:0]             wdata;
        logic [bytesPerWord-1:0] byteEn;
        int                      delay;
        reset    = 1'b1;
        cpuReq   = '0;
        memDelay = 1;
        repeat (resetCycles) @(negedge CLK);
        reset = 1'b0;
        repeat (4) @(negedge CLK);  // idle after reset

        // directed: miss, hits, conflict eviction, write hit and write miss
        runOp(1'b0, makeAddr(2'd0, 2'd0, 2'd1), '0, '0, 3);
        runOp(1'b0, makeAddr(2'd0, 2'd0, 2'd1), '0, '0, 1);
        runOp(1'b0, makeAddr(2'd0, 2'd0, 2'd2), '0, '0, 1);
        runOp(1'b0, makeAddr(2'd2, 2'd0, 2'd1), '0, '0, 6);
        runOp(1'b0, makeAddr(2'd0, 2'd0, 2'd1), '0, '0, 2);
        runOp(1'b1, makeAddr(2'd0, 2'd0, 2'd1), 32'hA1B2_C3D4, 4'b0101, 4);
        runOp(1'b0, makeAddr(2'd0, 2'd0, 2'd1), '0, '0, 1);
        runOp(1'b1, makeAddr(2'd3, 2'd1, 2'd0), 32'h1357_9BDF, 4'b1000, 5);
        runOp(1'b0, makeAddr(2'd3, 2'd1, 2'd0), '0, '0, 2);

        // random mix over the 64 word addresses
        for (int n = 0; n < numRandomOps; n++) begin
            isWrite = 1'(takeBits(1));
            tagSel  = 2'(takeBits(2));
            setSel  = 2'(takeBits(2));
            wordSel = 2'(takeBits(2));
            wdata   = takeBits(32);
            byteEn  = 4'(takeBits(4));
            delay   = 1 + int'(takeBits(8) % maxMemDelay);
            runOp(isWrite, makeAddr(tagSel, setSel, wordSel), wdata, byteEn, delay);
        end

        if (l1DataCache_i.controller.protocolChecks.protocolErrors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("port protocol assertions failed during the run");
            $display("*** TEST FAILED ***");
            $fatal(1, "protocol assertion failures");
        end
    end

endmodule

// File: verification/cacheProtocol_assert.sv
/*
 * Cache port protocol checks
 * Bound into the cache controller. Watches memory request stability,
 * the width of the done pulse and done only inside a request.
 */
`timescale 1ns/1ps

module cacheProtocolChecker import cacheBusPkg::*; (
    input logic    CLK,
    input logic    reset,
    input cpuReqT  cpuReq,
    input cpuRespT cpuResp,
    input memReqT  memReq,
    input memRespT memResp
);

    int protocolErrors = 0;  // read by the testbench at the end of the run

    // ==============================
    // memory port
    // ==============================
    memReqStable: assert property (@(posedge CLK) disable iff (reset)
        memReq.valid && !memResp.ready |=> memReq.valid && $stable(memReq))
    else begin
        $error("memory request changed or dropped before ready");
        protocolErrors++;
    end

    // ==============================
    // processor port
    // ==============================
    doneSinglePulse: assert property (@(posedge CLK) disable iff (reset)
        cpuResp.done |=> !cpuResp.done)
    else begin
        $error("done held for more than one cycle");
        protocolErrors++;
    end

    doneInsideRequest: assert property (@(posedge CLK) disable iff (reset)
        cpuResp.done |-> cpuReq.valid)
    else begin
        $error("done without a processor request");
        protocolErrors++;
    end

endmodule

bind cacheController cacheProtocolChecker protocolChecks (.*);

// File: source/l1DataCache.sv
/*
 * L1 data cache top
 * Direct-mapped, write-through, no write allocate. Joins the
 * controller with the data line array and the tag array.
 */
`timescale 1ns/1ps

module l1DataCache import cacheGeomPkg::*, cacheBusPkg::*; (
    input  logic    CLK,
    input  logic    reset,
    input  cpuReqT  cpuReq,
    output cpuRespT cpuResp,
    output memReqT  memReq,
    input  memRespT memResp
);

    // ==============================
    // array wiring
    // ==============================
    logic [indexWidth-1:0] tagIndex;
    logic                  tagWEn;
    logic                  tagREn;
    tagEntryT              tagWVal;
    tagEntryT              tagRVal;

    logic [indexWidth-1:0] dataIndex;
    logic                  dataWEn;
    logic                  dataREn;
    lineT                  dataWVal;
    lineT                  dataWMask;
    lineT                  dataRVal;

    cacheController controller (
        .CLK       (CLK),
        .reset     (reset),
        .cpuReq    (cpuReq),
        .cpuResp   (cpuResp),
        .memReq    (memReq),
        .memResp   (memResp),
        .tagIndex  (tagIndex),
        .tagWEn    (tagWEn),
        .tagREn    (tagREn),
        .tagWVal   (tagWVal),
        .tagRVal   (tagRVal),
        .dataIndex (dataIndex),
        .dataWEn   (dataWEn),
        .dataREn   (dataREn),
        .dataWVal  (dataWVal),
        .dataWMask (dataWMask),
        .dataRVal  (dataRVal)
    );

    // 128 bit lines, one per set
    sram #(
        .entryT (lineT),
        .height (numSets)
    ) dataArray (
        .CLK   (CLK),
        .index (dataIndex),
        .wEn   (dataWEn),
        .rEn   (dataREn),
        .wVal  (dataWVal),
        .wMask (dataWMask),
        .rVal  (dataRVal)
    );

    // tags are always written whole
    sram #(
        .entryT (tagEntryT),
        .height (numSets)
    ) tagArray (
        .CLK   (CLK),
        .index (tagIndex),
        .wEn   (tagWEn),
        .rEn   (tagREn),
        .wVal  (tagWVal),
        .wMask ('0),         // nothing protected
        .rVal  (tagRVal)
    );

endmodule

// File: source/cacheController.sv
/*
 * Cache controller
 * Lookup, line refill and write-through FSM of the direct-mapped L1
 * data cache. Holds the per-set valid bits and drives both SRAM arrays.
 * Stores never allocate, a store hit updates the cached word in place.
 */
`timescale 1ns/1ps

module cacheController import cacheGeomPkg::*, cacheBusPkg::*; (
    input  logic                  CLK,
    input  logic                  reset,
    input  cpuReqT                cpuReq,
    output cpuRespT               cpuResp,
    output memReqT                memReq,
    input  memRespT               memResp,
    // tag array
    output logic [indexWidth-1:0] tagIndex,
    output logic                  tagWEn,
    output logic                  tagREn,
    output tagEntryT              tagWVal,
    input  tagEntryT              tagRVal,
    // data array
    output logic [indexWidth-1:0] dataIndex,
    output logic                  dataWEn,
    output logic                  dataREn,
    output lineT                  dataWVal,
    output lineT                  dataWMask,
    input  lineT                  dataRVal
);

    typedef enum logic [2:0] {
        idle,      // wait for a request
        lookup,    // tag array read and compare
        memRead,   // line read outstanding
        fill,      // write refill line and tag
        memWrite,  // store outstanding, cached word updated on hit
        respond    // done pulse, read data from the data array
    } stateT;

    stateT              state;
    stateT              nextState;
    cacheAddrT          reqAddr;       // request address split into fields
    logic [numSets-1:0] validBits;     // one per set, cleared by reset
    logic               hit;
    logic               storePending;  // store hit not yet written to the array
    lineT               refillLine;    // line captured on memory ready
    lineT               storeLine;     // store word in its lane
    lineT               storeMask;     // protect mask for the store

    assign reqAddr = cacheAddrT'(cpuReq.addr);  // processor holds addr stable

    // hit only counts in lookup, tagRVal is poison elsewhere
    assign hit = validBits[reqAddr.index] && (tagRVal.tag == reqAddr.tag);

    // ==============================
    // state and control flops
    // ==============================
    always_ff @(posedge CLK) begin
        if (reset) begin
            state        <= idle;
            validBits    <= '0;    // whole cache empty
            storePending <= 1'b0;
        end else begin
            state <= nextState;
            if (state == fill) begin
                validBits[reqAddr.index] <= 1'b1;  // line now present
            end
            if (state == lookup) begin
                storePending <= cpuReq.write && hit;
            end else if (state == memWrite) begin
                storePending <= 1'b0;              // written in the first memWrite cycle
            end
        end
    end

    // refill payload
    always_ff @(posedge CLK) begin
        if (state == memRead && memResp.ready) begin
            refillLine <= memResp.rline;
        end
    end

    // ==============================
    // next state
    // ==============================
    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (cpuReq.valid) begin
                    nextState = lookup;
                end
            end
            lookup: begin
                if (cpuReq.write) begin
                    nextState = memWrite;  // write through on hit and miss
                end else if (hit) begin
                    nextState = respond;
                end else begin
                    nextState = memRead;
                end
            end
            memRead: begin
                if (memResp.ready) begin
                    nextState = fill;
                end
            end
            fill: begin
                nextState = respond;
            end
            memWrite: begin
                if (memResp.ready) begin
                    nextState = respond;
                end
            end
            respond: begin
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // ==============================
    // store steering and byte mask
    // ==============================
    always_comb begin
        storeLine = '0;
        storeMask = '1;  // protect everything by default
        storeLine[reqAddr.wordSel] = cpuReq.wdata;  // word into its lane
        for (int w = 0; w < lineWords; w++) begin
            for (int b = 0; b < bytesPerWord; b++) begin
                if (wordSelWidth'(w) == reqAddr.wordSel && cpuReq.byteEn[b]) begin
                    storeMask[w][b*8 +: 8] = 8'h00;  // open the addressed byte
                end
            end
        end
    end

    // ==============================
    // SRAM control
    // ==============================
    always_comb begin
        tagIndex    = reqAddr.index;         // both arrays share the set index
        dataIndex   = reqAddr.index;
        tagREn      = (state == lookup);
        tagWEn      = (state == fill);
        tagWVal.tag = reqAddr.tag;
        dataREn     = (state == respond);    // read data comes from the array
        dataWEn     = 1'b0;
        dataWVal    = storeLine;
        dataWMask   = storeMask;
        if (state == fill) begin
            dataWEn   = 1'b1;
            dataWVal  = refillLine;
            dataWMask = '0;                  // whole line replaced
        end else if (state == memWrite && storePending) begin
            dataWEn   = 1'b1;                // same cycle as the memory write request
        end
    end

    // ==============================
    // processor and memory ports
    // ==============================
    always_comb begin
        cpuResp.done  = (state == respond);
        cpuResp.rdata = dataRVal[reqAddr.wordSel];

        memReq.valid  = (state == memRead) || (state == memWrite);  // drops on the ready edge
        memReq.write  = (state == memWrite);
        memReq.wdata  = cpuReq.wdata;
        if (state == memWrite) begin
            memReq.addr   = cpuReq.addr;
            memReq.byteEn = cpuReq.byteEn;
        end else begin
            memReq.addr   = {reqAddr.tag, reqAddr.index, {offsetWidth{1'b0}}};  // line aligned
            memReq.byteEn = '1;
        end
    end

endmodule

// File: source/sram.sv
/*
 * Behavioural SRAM
 * Entry type and height are parameters. Writes land on the clock edge
 * and a set wMask bit keeps the stored bit. Reads are combinational.
 */
`timescale 1ns/1ps

module sram import cacheGeomPkg::*; #(
    parameter type entryT = lineT,
    parameter int  height = numSets
) (
    input  logic                      CLK,
    input  logic [$clog2(height)-1:0] index,
    input  logic                      wEn,
    input  logic                      rEn,
    input  entryT                     wVal,
    input  entryT                     wMask,   // 1 = protect stored bit
    output entryT                     rVal
);

    entryT mem [height];  // contents undefined after power up

    // poison pattern repeated over the whole entry width
    localparam logic [(($bits(entryT) + 31) / 32) * 32 - 1:0] poisonFill =
        {(($bits(entryT) + 31) / 32){sramPoison}};

    // protected bits keep their old value
    always_ff @(posedge CLK) begin
        if (wEn) begin
            mem[index] <= entryT'((wVal & ~wMask) | (mem[index] & wMask));
        end
    end

    // read straight from the array while enabled
    always_comb begin
        rVal = entryT'(poisonFill[$bits(entryT)-1:0]);  // visible when not reading
        if (rEn) begin
            rVal = mem[index];
        end
    end

endmodule

// File: source/cacheBusPkg.sv
/*
 * Cache port types
 * Request and response structs for the processor side and the
 * memory side of the L1 data cache.
 */
package cacheBusPkg;
    import cacheGeomPkg::*;

    // ==============================
    // processor port
    // ==============================
    typedef struct packed {
        logic                    valid;   // level, held until done
        logic                    write;   // 1 for a store
        logic [addrWidth-1:0]    addr;
        logic [wordWidth-1:0]    wdata;
        logic [bytesPerWord-1:0] byteEn;  // set bit = byte written
    } cpuReqT;

    typedef struct packed {
        logic                 done;   // one cycle pulse
        logic [wordWidth-1:0] rdata;  // valid for reads in the done cycle
    } cpuRespT;

    // ==============================
    // memory port
    // ==============================
    typedef struct packed {
        logic                    valid;   // level, held until ready
        logic                    write;
        logic [addrWidth-1:0]    addr;    // line aligned for reads
        logic [wordWidth-1:0]    wdata;
        logic [bytesPerWord-1:0] byteEn;
    } memReqT;

    typedef struct packed {
        logic ready;  // one cycle pulse
        lineT rline;  // refill line, only meaningful with ready on a read
    } memRespT;

endpackage

// File: source/cacheGeomPkg.sv
/*
 * Cache geometry
 * Sizes of the direct-mapped L1 data cache, how a byte address
 * splits into tag, index and offset, and the entry types kept in SRAM.
 */
package cacheGeomPkg;

    // ==============================
    // sizes
    // ==============================
    localparam int addrWidth    = 32;                                   // byte address
    localparam int wordWidth    = 32;                                   // processor word
    localparam int lineWords    = 4;                                    // words per line
    localparam int lineWidth    = lineWords * wordWidth;                // 128 bit line
    localparam int numSets      = 16;                                   // direct mapped
    localparam int bytesPerWord = wordWidth / 8;
    localparam int indexWidth   = $clog2(numSets);                      // 4
    localparam int offsetWidth  = $clog2(lineWidth / 8);                // 4, byte in line
    localparam int tagWidth     = addrWidth - indexWidth - offsetWidth; // 24
    localparam int wordSelWidth = $clog2(lineWords);
    localparam int byteSelWidth = $clog2(bytesPerWord);
    localparam logic [31:0] sramPoison = 32'hBAD0_BAD0;                // unread sram output

    // ==============================
    // address split and entries
    // ==============================
    typedef struct packed {
        logic [tagWidth-1:0]     tag;
        logic [indexWidth-1:0]   index;
        logic [wordSelWidth-1:0] wordSel;  // word within the line
        logic [byteSelWidth-1:0] byteSel;  // byte within the word
    } cacheAddrT;

    typedef logic [lineWords-1:0][wordWidth-1:0] lineT;  // word 0 in the low bits

    typedef struct packed {
        logic [tagWidth-1:0] tag;  // valid bits live in flops
    } tagEntryT;

endpackage
